// ==== hw/memCtrlPkg.sv ====
package memCtrlPkg;

    // byte-wide RAM address space
    localparam int addrWidth = 17;
    localparam int wordWidth = 32;
    localparam int byteWidth = 8;

    // byte offset inside a word
    localparam int offWidth = $clog2(wordWidth / byteWidth);

    // access length in bytes
    localparam int lenWidth = 3;
    localparam logic [lenWidth-1:0] lenByte = 3'd1;
    localparam logic [lenWidth-1:0] lenHalf = 3'd2;
    localparam logic [lenWidth-1:0] lenWord = 3'd4;

    // latched operation
    typedef enum logic [1:0] {
        opFetch,
        opLoad,
        opStore
    } memOp_t;

    // current RAM owner
    typedef enum logic [1:0] {
        ownIdle,
        ownData,
        ownFetch
    } owner_t;

    // byte sequencer states
    // drain waits for the last read byte to come back
    typedef enum logic [1:0] {
        seqIdle,
        seqIssue,
        seqDrain
    } seqState_t;

endpackage

// ==== hw/portArbiter.sv ====
`timescale 1ns/1ps

module portArbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memCtrlPkg::lenWidth-1:0]   dataLen,
    input  logic [memCtrlPkg::addrWidth-1:0]  dataAddr,
    input  logic [memCtrlPkg::wordWidth-1:0]  dataWdata,
    input  logic                              fetchEn,
    input  logic [memCtrlPkg::addrWidth-1:0]  fetchAddr,
    input  logic                              finish,
    output logic                              advance,
    output logic                              start,
    output memCtrlPkg::memOp_t                op,
    output logic [memCtrlPkg::lenWidth-1:0]   len,
    output logic [memCtrlPkg::addrWidth-1:0]  baseAddr,
    output logic [memCtrlPkg::wordWidth-1:0]  wdata,
    output memCtrlPkg::owner_t                owner
);

    // the only place the stall inputs are looked at
    assign advance = rdy && !ioBufferFull;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner    <= memCtrlPkg::ownIdle;
            start    <= 1'b0;
            op       <= memCtrlPkg::opFetch;
            len      <= memCtrlPkg::lenWord;
            baseAddr <= '0;
            wdata    <= '0;
        end else if (advance) begin
            // start lasts one enabled cycle
            start <= 1'b0;
            if (owner == memCtrlPkg::ownIdle) begin
                // data side wins a tie
                if (dataEn) begin
                    owner    <= memCtrlPkg::ownData;
                    start    <= 1'b1;
                    len      <= dataLen;
                    baseAddr <= dataAddr;
                    wdata    <= dataWdata;
                    if (dataStore) begin
                        op <= memCtrlPkg::opStore;
                    end else begin
                        op <= memCtrlPkg::opLoad;
                    end
                end else if (fetchEn) begin
                    owner    <= memCtrlPkg::ownFetch;
                    start    <= 1'b1;
                    op       <= memCtrlPkg::opFetch;
                    len      <= memCtrlPkg::lenWord;
                    baseAddr <= fetchAddr;
                end
            end else if (finish) begin
                // back to idle after the done cycle
                owner <= memCtrlPkg::ownIdle;
            end
        end
    end

endmodule

// ==== hw/byteSequencer.sv ====
`timescale 1ns/1ps

module byteSequencer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              advance,
    input  logic                              start,
    input  memCtrlPkg::memOp_t                op,
    input  logic [memCtrlPkg::lenWidth-1:0]   len,
    input  logic [memCtrlPkg::addrWidth-1:0]  baseAddr,
    input  logic [memCtrlPkg::wordWidth-1:0]  wdata,
    output logic [memCtrlPkg::addrWidth-1:0]  memAddr,
    output logic                              memWrite,
    output logic [memCtrlPkg::byteWidth-1:0]  memWdata,
    output logic                              beat,
    output logic [memCtrlPkg::offWidth-1:0]   beatIndex,
    output logic                              lastBeat,
    output logic                              storeDone
);

    memCtrlPkg::seqState_t state;

    logic [memCtrlPkg::offWidth-1:0] offset;
    logic [memCtrlPkg::lenWidth-1:0] lastOffset;
    logic                            active;
    logic                            isStore;

    // byte 0 goes out while start is still up
    assign active = (state == memCtrlPkg::seqIssue) ||
                    (state == memCtrlPkg::seqIdle && start);

    assign isStore    = (op == memCtrlPkg::opStore);
    assign lastOffset = len - memCtrlPkg::lenByte;
    assign lastBeat   = active && (memCtrlPkg::lenWidth'(offset) == lastOffset);

    // RAM side
    assign memAddr  = baseAddr + memCtrlPkg::addrWidth'(offset);
    assign memWrite = advance && active && isStore;

    // little-endian byte of the store word
    assign memWdata = wdata[offset * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth];

    // read beats for the output side
    assign beat      = active && !isStore;
    assign beatIndex = offset;

    // last write byte ends a store
    assign storeDone = active && isStore && lastBeat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= memCtrlPkg::seqIdle;
            offset <= '0;
        end else if (advance) begin
            case (state)
                memCtrlPkg::seqIdle: begin
                    if (start) begin
                        if (lastBeat) begin
                            // single byte access
                            offset <= '0;
                            if (isStore) begin
                                state <= memCtrlPkg::seqIdle;
                            end else begin
                                state <= memCtrlPkg::seqDrain;
                            end
                        end else begin
                            offset <= offset + memCtrlPkg::offWidth'(1);
                            state  <= memCtrlPkg::seqIssue;
                        end
                    end
                end

                memCtrlPkg::seqIssue: begin
                    if (lastBeat) begin
                        offset <= '0;
                        if (isStore) begin
                            state <= memCtrlPkg::seqIdle;
                        end else begin
                            state <= memCtrlPkg::seqDrain;
                        end
                    end else begin
                        offset <= offset + memCtrlPkg::offWidth'(1);
                    end
                end

                memCtrlPkg::seqDrain: begin
                    // last byte is on memRdata this cycle
                    state <= memCtrlPkg::seqIdle;
                end

                default: begin
                    state  <= memCtrlPkg::seqIdle;
                    offset <= '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/wordAssembler.sv ====
`timescale 1ns/1ps

module wordAssembler (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              advance,
    input  memCtrlPkg::memOp_t                op,
    input  logic [memCtrlPkg::lenWidth-1:0]   len,
    input  logic [memCtrlPkg::byteWidth-1:0]  memRdata,
    input  logic                              beat,
    input  logic [memCtrlPkg::offWidth-1:0]   beatIndex,
    input  logic                              lastBeat,
    input  logic                              storeDone,
    output logic                              dataDone,
    output logic [memCtrlPkg::wordWidth-1:0]  dataRdata,
    output logic                              fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0]  fetchInst,
    output logic                              finish
);

    logic                             beatQ;
    logic                             lastQ;
    logic [memCtrlPkg::offWidth-1:0]  idxQ;
    logic [memCtrlPkg::wordWidth-1:0] collector;
    logic [memCtrlPkg::wordWidth-1:0] merged;
    logic [memCtrlPkg::wordWidth-1:0] loadWord;
    logic [memCtrlPkg::wordWidth-1:0] dataRdataQ;
    logic [memCtrlPkg::wordWidth-1:0] fetchInstQ;
    logic                             readDone;
    logic                             loadDone;

    // flags follow the RAM by one enabled cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            beatQ      <= 1'b0;
            lastQ      <= 1'b0;
            idxQ       <= '0;
            dataRdataQ <= '0;
            fetchInstQ <= '0;
        end else if (advance) begin
            beatQ <= beat;
            lastQ <= beat && lastBeat;
            idxQ  <= beatIndex;
            if (loadDone) begin
                dataRdataQ <= loadWord;
            end
            if (fetchDone) begin
                fetchInstQ <= merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && beatQ) begin
            collector[idxQ * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth] <= memRdata;
        end
    end

    // current byte goes straight into the result
    always_comb begin
        merged = collector;
        merged[idxQ * memCtrlPkg::byteWidth +: memCtrlPkg::byteWidth] = memRdata;
    end

    // zero-extend above len bytes
    always_comb begin
        case (len)
            memCtrlPkg::lenByte: begin
                loadWord = {{(memCtrlPkg::wordWidth - memCtrlPkg::byteWidth){1'b0}},
                            merged[memCtrlPkg::byteWidth-1:0]};
            end
            memCtrlPkg::lenHalf: begin
                loadWord = {{(memCtrlPkg::wordWidth - 2 * memCtrlPkg::byteWidth){1'b0}},
                            merged[2*memCtrlPkg::byteWidth-1:0]};
            end
            default: begin
                loadWord = merged;
            end
        endcase
    end

    assign readDone  = advance && beatQ && lastQ;
    assign loadDone  = readDone && (op == memCtrlPkg::opLoad);
    assign fetchDone = readDone && (op == memCtrlPkg::opFetch);
    assign dataDone  = loadDone || (advance && storeDone);
    assign finish    = dataDone || fetchDone;

    // new value shows in the done cycle, then held
    assign dataRdata = loadDone ? loadWord : dataRdataQ;
    assign fetchInst = fetchDone ? merged : fetchInstQ;

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,
    input  logic                              dataEn,
    input  logic                              dataStore,
    input  logic [memCtrlPkg::lenWidth-1:0]   dataLen,
    input  logic [memCtrlPkg::addrWidth-1:0]  dataAddr,
    input  logic [memCtrlPkg::wordWidth-1:0]  dataWdata,
    output logic                              dataDone,
    output logic [memCtrlPkg::wordWidth-1:0]  dataRdata,
    input  logic                              fetchEn,
    input  logic [memCtrlPkg::addrWidth-1:0]  fetchAddr,
    output logic                              fetchDone,
    output logic [memCtrlPkg::wordWidth-1:0]  fetchInst,
    output logic [memCtrlPkg::addrWidth-1:0]  memAddr,
    output logic                              memWrite,
    output logic [memCtrlPkg::byteWidth-1:0]  memWdata,
    input  logic [memCtrlPkg::byteWidth-1:0]  memRdata,
    output memCtrlPkg::owner_t                owner
);

    logic                             advance;
    logic                             start;
    memCtrlPkg::memOp_t               op;
    logic [memCtrlPkg::lenWidth-1:0]  len;
    logic [memCtrlPkg::addrWidth-1:0] baseAddr;
    logic [memCtrlPkg::wordWidth-1:0] wdata;
    logic                             beat;
    logic [memCtrlPkg::offWidth-1:0]  beatIndex;
    logic                             lastBeat;
    logic                             storeDone;
    logic                             finish;

    portArbiter arbiter0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .dataAddr     (dataAddr),
        .dataWdata    (dataWdata),
        .fetchEn      (fetchEn),
        .fetchAddr    (fetchAddr),
        .finish       (finish),
        .advance      (advance),
        .start        (start),
        .op           (op),
        .len          (len),
        .baseAddr     (baseAddr),
        .wdata        (wdata),
        .owner        (owner)
    );

    byteSequencer sequencer0 (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .start     (start),
        .op        (op),
        .len       (len),
        .baseAddr  (baseAddr),
        .wdata     (wdata),
        .memAddr   (memAddr),
        .memWrite  (memWrite),
        .memWdata  (memWdata),
        .beat      (beat),
        .beatIndex (beatIndex),
        .lastBeat  (lastBeat),
        .storeDone (storeDone)
    );

    wordAssembler assembler0 (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .op        (op),
        .len       (len),
        .memRdata  (memRdata),
        .beat      (beat),
        .beatIndex (beatIndex),
        .lastBeat  (lastBeat),
        .storeDone (storeDone),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .finish    (finish)
    );

endmodule

// ==== sim/memCtrlAsserts.sv ====
`timescale 1ns/1ps

module memCtrlAsserts (
    input logic                             clk,
    input logic                             rst,
    input logic                             advance,
    input logic                             memWrite,
    input logic                             dataDone,
    input logic                             fetchDone,
    input logic [memCtrlPkg::addrWidth-1:0] memAddr,
    input memCtrlPkg::owner_t               owner,
    input memCtrlPkg::seqState_t            seqState
);

    // only the data port writes
    writeOwner: assert property (@(posedge clk) disable iff (rst)
        memWrite |-> owner == memCtrlPkg::ownData)
        else $error("memWrite high while the data port does not own the RAM");

    oneDone: assert property (@(posedge clk) disable iff (rst)
        !(dataDone && fetchDone))
        else $error("dataDone and fetchDone high in the same cycle");

    // stalled edge leaves registered state alone
    frozen: assert property (@(posedge clk)
        !rst && !advance |=> $stable(owner) && $stable(memAddr) && $stable(seqState))
        else $error("state changed across a stalled edge");

    idleAfterReset: assert property (@(posedge clk)
        rst |=> owner == memCtrlPkg::ownIdle)
        else $error("owner not idle after reset");

endmodule

bind memCtrl memCtrlAsserts asserts0 (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .memWrite  (memWrite),
    .dataDone  (dataDone),
    .fetchDone (fetchDone),
    .memAddr   (memAddr),
    .owner     (owner),
    .seqState  (sequencer0.state)
);

// ==== sim/memCtrlTb.sv ====
`timescale 1ns/1ps

module memCtrlTb;

    localparam int numTrans = 200;
    // worst case for a data access followed by a fetch under heavy stalls
    localparam int cycleBudget = 200;
    localparam int watchdogNs = (numTrans * cycleBudget + 20) * 10;
    localparam int memSize = 1 << memCtrlPkg::addrWidth;
    localparam int windowLo = 'h400;
    // a 4-byte store at the top of the window spills 3 bytes past it
    localparam int windowHi = windowLo + 32 + 3;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    logic dataEn;
    logic dataStore;
    logic [memCtrlPkg::lenWidth-1:0] dataLen;
    logic [memCtrlPkg::addrWidth-1:0] dataAddr;
    logic [memCtrlPkg::wordWidth-1:0] dataWdata;
    logic dataDone;
    logic [memCtrlPkg::wordWidth-1:0] dataRdata;
    logic fetchEn;
    logic [memCtrlPkg::addrWidth-1:0] fetchAddr;
    logic fetchDone;
    logic [memCtrlPkg::wordWidth-1:0] fetchInst;
    logic [memCtrlPkg::addrWidth-1:0] memAddr;
    logic memWrite;
    logic [7:0] memWdata;
    logic [7:0] memRdata;
    memCtrlPkg::owner_t owner;

    logic [7:0] ram [memSize];
    logic [7:0] shadow [memSize];
    logic [15:0] lfsrState;
    int errorCount;
    int checkCount;

    memCtrl dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // byte RAM with one-cycle read, frozen by the same stall inputs
    always @(posedge clk) begin
        if (memWrite) begin
            if (int'(memAddr) < windowLo || int'(memAddr) >= windowHi) begin
                reportFailure($sformatf("write outside the test window at %h", memAddr));
            end
            ram[memAddr] = memWdata;
        end
        if (rst) begin
            memRdata <= '0;
        end else if (rdy && !ioBufferFull) begin
            memRdata <= ram[memAddr];
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsrState[15]};
            lfsrState = {lfsrState[14:0],
                         lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
        end
        return v;
    endfunction

    // little-endian from the shadow, zero above len bytes
    function automatic logic [31:0] expectedWord(input logic [memCtrlPkg::addrWidth-1:0] addr,
                                                 input int len);
        logic [31:0] w;
        int k;
        w = '0;
        for (k = 0; k < len; k++) begin
            w[k*8 +: 8] = shadow[addr + memCtrlPkg::addrWidth'(k)];
        end
        return w;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        errorCount++;
        $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // rdy low about 1 in 4, buffer full about 1 in 8
    task automatic driveStalls();
        rdy = (randomBits(2) != 32'd0);
        ioBufferFull = (randomBits(3) == 32'd0);
    endtask

    task automatic compareWindow();
        int a;
        for (a = windowLo; a < windowHi; a++) begin
            checkCount++;
            if (ram[17'(a)] !== shadow[17'(a)]) begin
                reportMismatch($sformatf("ram[%h]", a), 32'(ram[17'(a)]), 32'(shadow[17'(a)]));
            end
        end
    endtask

    task automatic runAccess(input logic doData, input logic store, input logic doFetch,
                             input logic [memCtrlPkg::lenWidth-1:0] len,
                             input logic [memCtrlPkg::addrWidth-1:0] dAddr,
                             input logic [memCtrlPkg::wordWidth-1:0] wd,
                             input logic [memCtrlPkg::addrWidth-1:0] fAddr);
        logic dataPending;
        logic fetchPending;
        logic storeWritten;
        int k;
        @(negedge clk);
        dataEn = doData;
        dataStore = store;
        dataLen = len;
        dataAddr = dAddr;
        dataWdata = wd;
        fetchEn = doFetch;
        fetchAddr = fAddr;
        dataPending = doData;
        fetchPending = doFetch;
        storeWritten = 1'b0;
        driveStalls();
        while (dataPending || fetchPending) begin
            // outputs settle shortly after the falling edge
            #1;
            checkCount++;
            if (memWrite && !(rdy && !ioBufferFull)) begin
                reportFailure("memWrite high in a stalled cycle");
            end
            if (dataPending && owner == memCtrlPkg::ownFetch) begin
                reportFailure("fetch port holds the RAM while a data request waits");
            end
            if (!dataPending && owner == memCtrlPkg::ownData) begin
                reportFailure("data port holds the RAM without a data request");
            end
            if (dataDone) begin
                if (!dataPending) begin
                    reportFailure("dataDone without a data request");
                end else begin
                    if (owner !== memCtrlPkg::ownData) begin
                        reportMismatch("owner", 32'(owner), 32'(memCtrlPkg::ownData));
                    end
                    if (store) begin
                        for (k = 0; k < int'(len); k++) begin
                            shadow[dAddr + memCtrlPkg::addrWidth'(k)] = wd[k*8 +: 8];
                        end
                        storeWritten = 1'b1;
                    end else if (dataRdata !== expectedWord(dAddr, int'(len))) begin
                        reportMismatch("dataRdata", dataRdata, expectedWord(dAddr, int'(len)));
                    end
                end
                dataPending = 1'b0;
            end
            if (fetchDone) begin
                if (!fetchPending) begin
                    reportFailure("fetchDone without a fetch request");
                end else if (dataPending) begin
                    reportFailure("fetchDone came before the pending dataDone");
                end else begin
                    if (owner !== memCtrlPkg::ownFetch) begin
                        reportMismatch("owner", 32'(owner), 32'(memCtrlPkg::ownFetch));
                    end
                    if (fetchInst !== expectedWord(fAddr, int'(memCtrlPkg::lenWord))) begin
                        reportMismatch("fetchInst", fetchInst,
                                       expectedWord(fAddr, int'(memCtrlPkg::lenWord)));
                    end
                end
                fetchPending = 1'b0;
            end
            @(negedge clk);
            // last store byte was written on the edge just passed
            if (storeWritten) begin
                compareWindow();
                storeWritten = 1'b0;
            end
            if (!dataPending) begin
                dataEn = 1'b0;
            end
            if (!fetchPending) begin
                fetchEn = 1'b0;
            end
            driveStalls();
        end
    endtask

    initial begin
        int t;
        int a;
        int kind;
        int lenPick;
        logic [memCtrlPkg::lenWidth-1:0] len;
        logic [memCtrlPkg::addrWidth-1:0] dAddr;
        logic [memCtrlPkg::addrWidth-1:0] fAddr;
        logic [memCtrlPkg::wordWidth-1:0] wd;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = memCtrlPkg::lenByte;
        dataAddr = '0;
        dataWdata = '0;
        fetchEn = 1'b0;
        fetchAddr = '0;
        lfsrState = 16'd43;
        errorCount = 0;
        checkCount = 0;
        for (a = 0; a < memSize; a++) begin
            ram[17'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 16);
            shadow[17'(a)] = ram[17'(a)];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        checkCount += 6;
        if (owner !== memCtrlPkg::ownIdle) begin
            reportMismatch("owner", 32'(owner), 32'(memCtrlPkg::ownIdle));
        end
        if (dataDone !== 1'b0 || fetchDone !== 1'b0 || memWrite !== 1'b0) begin
            reportFailure("a done pulse or memWrite is high right after reset");
        end
        if (memAddr !== '0) begin
            reportMismatch("memAddr", 32'(memAddr), 32'd0);
        end
        if (memWdata !== '0) begin
            reportMismatch("memWdata", 32'(memWdata), 32'd0);
        end
        if (dataRdata !== '0) begin
            reportMismatch("dataRdata", dataRdata, 32'd0);
        end
        if (fetchInst !== '0) begin
            reportMismatch("fetchInst", fetchInst, 32'd0);
        end
        // kind 0-1 fetch, 2-3 load, 4-5 store, 6-7 data and fetch together
        for (t = 0; t < numTrans; t++) begin
            kind = int'(randomBits(3));
            lenPick = int'(randomBits(2));
            len = (lenPick == 0) ? memCtrlPkg::lenByte :
                  (lenPick == 1) ? memCtrlPkg::lenHalf : memCtrlPkg::lenWord;
            dAddr = 17'(windowLo + int'(randomBits(5)));
            fAddr = 17'(windowLo + int'(randomBits(5)));
            wd = randomBits(32);
            runAccess(kind >= 2, kind == 4 || kind == 5 || kind == 7,
                      kind <= 1 || kind >= 6, len, dAddr, wd, fAddr);
        end
        repeat (4) @(negedge clk);
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        reportFailure("timeout, the transactions did not complete in time");
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/memCtrlPkg.sv
hw/portArbiter.sv
hw/byteSequencer.sv
hw/wordAssembler.sv
hw/memCtrl.sv
sim/memCtrlAsserts.sv
sim/memCtrlTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f vlog.f --top-module memCtrlTb -o memCtrlSim \
    || { echo "build failed"; exit 1; }

./obj_dir/memCtrlSim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation stopped with an error"; exit 1; }

cat sim.log

grep -q "Test failures found" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "RESULT: FAIL, no pass line in log"; exit 1; }
echo "RESULT: PASS"
